// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_store_commit_buffer
FILELIST  ?= store_commit_buffer.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q '^=== PASS ===$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/scb_checker.sv
`timescale 1ns/10ps

module scb_checker
    import scb_addr_pkg::*;
(
    input logic               clk,
    input logic               rst,
    input logic               store_en,
    input logic               store_conflict,
    input logic               cache_req,
    input logic [PADDR_W-1:0] cache_addr,
    input logic               cache_ack
);

    req_hold: assert property (@(posedge clk) disable iff (!rst)
        cache_req && !cache_ack |=> cache_req && $stable(cache_addr))
        else $error("cache request changed before the cache answered");

    req_release: assert property (@(posedge clk) disable iff (!rst)
        $fell(cache_req) |-> $past(cache_ack))
        else $error("cache request dropped without an ack");

    // ack must be seen low before the next line goes out.
    req_after_ack: assert property (@(posedge clk) disable iff (!rst)
        $rose(cache_req) |-> !cache_ack)
        else $error("new cache request started while ack was still high");

    stall_needs_store: assert property (@(posedge clk) disable iff (!rst)
        store_conflict |-> store_en)
        else $error("store stall raised with no store pending");

endmodule

// File: bench/tb_store_commit_buffer.sv
`timescale 1ns/10ps

module tb_store_commit_buffer;
    import scb_addr_pkg::*, scb_line_pkg::*;

    localparam logic [2:0] OP_IDLE = 3'd0;
    localparam logic [2:0] OP_ST   = 3'd1;
    localparam logic [2:0] OP_STX  = 3'd2; // store that must stall.
    localparam logic [2:0] OP_LD   = 3'd3;
    localparam logic [2:0] OP_HOLD = 3'd4; // cache stops answering.
    localparam logic [2:0] OP_FL   = 3'd5;
    localparam int NROWS        = 20;
    localparam int DRAIN_CYCLES = 200;
    localparam int LIMIT_CYCLES = NROWS * 20 + DRAIN_CYCLES + 8;

    typedef struct packed {
        logic [2:0]  op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  mask;
        logic [31:0] exp_data;
        logic [3:0]  exp_mask;
    } row_t;

    row_t stim [NROWS] = '{
        '{OP_ST,   32'h0000_1234, 32'h1122_3344, 4'b0011, 32'h0,         4'b0000},
        '{OP_ST,   32'h0000_1234, 32'hAABB_CCDD, 4'b0110, 32'h0,         4'b0000},
        '{OP_LD,   32'h0000_1234, 32'h0,         4'b0000, 32'h00BB_CC44, 4'b0111},
        '{OP_LD,   32'h0000_5674, 32'h0,         4'b0000, 32'h0,         4'b0000},
        '{OP_LD,   32'h0001_1234, 32'h0,         4'b0000, 32'h0,         4'b0000},
        '{OP_LD,   32'h0000_1238, 32'h0,         4'b0000, 32'h0,         4'b0000},
        '{OP_HOLD, 32'h0,         32'h0,         4'b0000, 32'h0,         4'b0000},
        '{OP_ST,   32'h0000_2000, 32'h0101_0101, 4'b1111, 32'h0,         4'b0000},
        '{OP_ST,   32'h0000_3004, 32'h0202_0202, 4'b1100, 32'h0,         4'b0000},
        '{OP_ST,   32'h0000_4008, 32'h0303_0303, 4'b0001, 32'h0,         4'b0000},
        '{OP_ST,   32'h0000_500C, 32'h0404_0404, 4'b1000, 32'h0,         4'b0000},
        '{OP_ST,   32'h0001_6000, 32'h0505_0505, 4'b0110, 32'h0,         4'b0000},
        '{OP_ST,   32'h0000_7010, 32'h0606_0606, 4'b1111, 32'h0,         4'b0000},
        '{OP_ST,   32'h0000_8020, 32'h0707_0707, 4'b0011, 32'h0,         4'b0000},
        '{OP_STX,  32'h0000_9000, 32'h0808_0808, 4'b1111, 32'h0,         4'b0000},
        '{OP_ST,   32'h0000_3004, 32'h0A0B_0C0D, 4'b0011, 32'h0,         4'b0000},
        '{OP_LD,   32'h0000_3004, 32'h0,         4'b0000, 32'h0202_0C0D, 4'b1111},
        '{OP_FL,   32'h0,         32'h0,         4'b0000, 32'h0,         4'b0000},
        '{OP_IDLE, 32'h0,         32'h0,         4'b0000, 32'h0,         4'b0000},
        '{OP_LD,   32'h0000_1234, 32'h0,         4'b0000, 32'h0,         4'b0000}
    };

    logic                    clk;
    logic                    rst;
    logic                    flush;
    logic                    store_en;
    logic [PADDR_W-1:0]      store_addr;
    logic [WORD_W-1:0]       store_data;
    logic [WORD_BYTES-1:0]   store_mask;
    logic                    store_conflict;
    logic                    load_en;
    logic [PAGE_W-1:0]       load_offset;
    logic [PTAG_W-1:0]       load_ptag;
    logic [WORD_W-1:0]       fwd_data;
    logic [WORD_BYTES-1:0]   fwd_mask;
    logic                    cache_req;
    logic [PADDR_W-1:0]      cache_addr;
    logic [BANKS*WORD_W-1:0] cache_data;
    logic [LINE_BYTES-1:0]   cache_mask;
    logic                    cache_ack;
    logic                    empty;

    logic                    ack_en;
    integer                  seed;
    int                      delay;
    int                      errors;
    int                      checks;
    logic [LINE_W-1:0]       wline;
    logic [127:0]            ref_data [logic [LINE_W-1:0]];
    logic [15:0]             ref_mask [logic [LINE_W-1:0]];
    logic [127:0]            mem_data [logic [LINE_W-1:0]];
    logic [15:0]             mem_mask [logic [LINE_W-1:0]];
    int                      mem_cnt  [logic [LINE_W-1:0]];

    store_commit_buffer #(.ENTRIES(8), .COUNTER_W(3), .THRESH(6)) u_store_commit_buffer (.*);

    bind store_commit_buffer scb_checker u_checker (
        .clk            (clk),
        .rst            (rst),
        .store_en       (store_en),
        .store_conflict (store_conflict),
        .cache_req      (cache_req),
        .cache_addr     (cache_addr),
        .cache_ack      (cache_ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    // cache model acks after 1 to 4 cycles and keeps each line written.
    initial begin
        seed      = 32'h4ac20873;
        cache_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (cache_req && ack_en) begin
                delay = {$random(seed)} % 4 + 1;
                repeat (delay) @(negedge clk);
                check_value("cache_addr", cache_addr[LINE_OFS_W-1:0], '0);
                wline           = cache_addr[PADDR_W-1:LINE_OFS_W];
                mem_cnt[wline]  = mem_cnt.exists(wline) ? mem_cnt[wline] + 1 : 1;
                mem_data[wline] = cache_data;
                mem_mask[wline] = cache_mask;
                cache_ack       = 1'b1;
                while (cache_req) @(negedge clk);
                delay = {$random(seed)} % 4;
                repeat (delay) @(negedge clk); // ack may linger after req drops.
                cache_ack = 1'b0;
            end
        end
    end

    function automatic logic [127:0] byte_mask(input logic [15:0] m);
        logic [127:0] r;
        for (int k = 0; k < 16; k++) begin
            r[k*8 +: 8] = {8{m[k]}};
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %0h exp %0h", name, got, exp);
        end
    endtask

    task automatic ref_store(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] mask);
        logic [LINE_W-1:0] line;
        int                base;
        line = addr[31:4];
        base = int'(addr[3:2]) * 4;
        if (!ref_mask.exists(line)) begin
            ref_mask[line] = '0;
            ref_data[line] = '0;
        end
        for (int k = 0; k < 4; k++) begin
            if (mask[k]) begin
                ref_data[line][(base+k)*8 +: 8] = data[k*8 +: 8]; // later store wins.
                ref_mask[line][base+k]          = 1'b1;
            end
        end
    endtask

    task automatic run_row(input row_t r);
        case (r.op)
            OP_ST, OP_STX: begin
                @(negedge clk);
                store_en   = 1'b1;
                store_addr = r.addr;
                store_data = r.data;
                store_mask = r.mask;
                #1;
                check_value("store_conflict", store_conflict, r.op == OP_STX);
                if (!store_conflict) begin
                    ref_store(r.addr, r.data, r.mask);
                end
                @(negedge clk);
                store_en = 1'b0;
            end
            OP_LD: begin
                @(negedge clk);
                load_en     = 1'b1;
                load_offset = r.addr[11:0];
                @(negedge clk);
                load_en   = 1'b0;
                load_ptag = r.addr[31:12]; // tag comes one cycle late.
                @(negedge clk);
                check_value("fwd_mask", fwd_mask, r.exp_mask);
                check_value("fwd_data", fwd_data & byte_mask({12'b0, r.exp_mask}),
                            r.exp_data & byte_mask({12'b0, r.exp_mask}));
            end
            OP_HOLD: begin
                @(negedge clk);
                ack_en = 1'b0;
            end
            OP_FL: begin
                @(negedge clk);
                ack_en = 1'b1;
                flush  = 1'b1;
                @(negedge clk);
                flush = 1'b0;
                while (!empty) @(negedge clk);
                check_value("cache_req", cache_req, 1'b0);
            end
            default: @(negedge clk);
        endcase
    endtask

    task automatic compare_lines();
        foreach (ref_mask[line]) begin
            if (!mem_cnt.exists(line)) begin
                errors++;
                $display("line %h never reached the cache", line);
            end else begin
                if (mem_cnt[line] != 1) begin
                    errors++;
                    $display("line %h was written %0d times", line, mem_cnt[line]);
                end
                check_value("cache_mask", mem_mask[line], ref_mask[line]);
                check_value("cache_data", mem_data[line] & byte_mask(ref_mask[line]),
                            ref_data[line] & byte_mask(ref_mask[line]));
            end
        end
        foreach (mem_cnt[line]) begin
            if (!ref_mask.exists(line)) begin
                errors++;
                $display("cache got line %h that was never stored", line);
            end
        end
    endtask

    initial begin
        errors      = 0;
        checks      = 0;
        ack_en      = 1'b1;
        rst         = 1'b0;
        flush       = 1'b0;
        store_en    = 1'b0;
        store_addr  = '0;
        store_data  = '0;
        store_mask  = '0;
        load_en     = 1'b0;
        load_offset = '0;
        load_ptag   = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        #1;
        check_value("store_conflict", store_conflict, 1'b0);
        check_value("cache_req", cache_req, 1'b0);
        check_value("fwd_mask", fwd_mask, 4'b0);
        check_value("empty", empty, 1'b1);
        for (int i = 0; i < NROWS; i++) begin
            run_row(stim[i]);
        end
        repeat (4) @(negedge clk);
        check_value("empty", empty, 1'b1);
        compare_lines();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: hdl/scb_addr_pkg.sv
package scb_addr_pkg;

    localparam int PADDR_W    = 32;
    localparam int BYTE_W     = 2;                    // byte within a bank word.
    localparam int BANK_W     = 2;                    // bank within a line.
    localparam int LINE_OFS_W = BYTE_W + BANK_W;
    localparam int LINE_W     = PADDR_W - LINE_OFS_W; // line address.
    localparam int PAGE_W     = 12;
    localparam int PTAG_W     = PADDR_W - PAGE_W;

    // one physical address, seen by stores as line/bank/byte
    // and by loads as physical tag plus page offset.
    typedef union packed {
        struct packed {
            logic [LINE_W-1:0] line;
            logic [BANK_W-1:0] bank;
            logic [BYTE_W-1:0] byte_sel;
        } st;
        struct packed {
            logic [PTAG_W-1:0] ptag;
            logic [PAGE_W-1:0] page_ofs;
        } ld;
    } scb_paddr_u;

endpackage

// File: hdl/scb_data_array.sv
`timescale 1ns/10ps

module scb_data_array
    import scb_addr_pkg::*, scb_line_pkg::*;
#(
    parameter int  ENTRIES = 8,
    localparam int IDX_W   = $clog2(ENTRIES)
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wr_en,
    input  logic [IDX_W-1:0]        wr_idx,
    input  logic [BANK_W-1:0]       wr_bank,
    input  logic                    new_line,
    input  logic [WORD_W-1:0]       store_data,
    input  logic [WORD_BYTES-1:0]   store_mask,
    input  logic                    fwd_req,
    input  logic [IDX_W-1:0]        fwd_idx,
    input  logic [BANK_W-1:0]       fwd_bank,
    output logic [WORD_W-1:0]       fwd_data,
    output logic [WORD_BYTES-1:0]   fwd_mask,
    input  logic                    drain_req,
    input  logic [IDX_W-1:0]        drain_idx,
    output logic [BANKS*WORD_W-1:0] line_data,
    output logic [LINE_BYTES-1:0]   line_mask
);
    logic [WORD_BYTES-1:0] bank_we    [BANKS];
    logic [WORD_W-1:0]     rdf_data   [BANKS];
    logic [WORD_BYTES-1:0] rdf_mask   [BANKS];
    logic [WORD_W-1:0]     rdd_data   [BANKS];
    logic [WORD_BYTES-1:0] rdd_mask   [BANKS];

    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        // only the addressed bank takes bytes, the rest just see new_line.
        assign bank_we[b] = store_mask & {WORD_BYTES{wr_bank == BANK_W'(b)}};

        scb_data_bank #(.ENTRIES(ENTRIES)) u_bank (
            .clk           (clk),
            .rst           (rst),
            .wr_en         (wr_en),
            .wr_idx        (wr_idx),
            .new_line      (new_line),
            .wr_mask       (bank_we[b]),
            .wr_data       (store_data),
            .rd_idx_fwd    (fwd_idx),
            .rd_idx_drain  (drain_idx),
            .rd_data_fwd   (rdf_data[b]),
            .rd_mask_fwd   (rdf_mask[b]),
            .rd_data_drain (rdd_data[b]),
            .rd_mask_drain (rdd_mask[b])
        );
    end

    always_ff @(posedge clk) begin
        if (fwd_req) begin
            fwd_data <= rdf_data[fwd_bank];
        end
        if (drain_req) begin
            for (int b = 0; b < BANKS; b++) begin
                line_data[b*WORD_W +: WORD_W]         <= rdd_data[b];
                line_mask[b*WORD_BYTES +: WORD_BYTES] <= rdd_mask[b];
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            fwd_mask <= '0;
        end else begin
            fwd_mask <= fwd_req ? rdf_mask[fwd_bank] : '0; // miss reads as no bytes.
        end
    end

endmodule

// File: hdl/scb_data_bank.sv
`timescale 1ns/10ps

module scb_data_bank
    import scb_line_pkg::*;
#(
    parameter int  ENTRIES = 8,
    localparam int IDX_W   = $clog2(ENTRIES)
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_en,
    input  logic [IDX_W-1:0]      wr_idx,
    input  logic                  new_line,
    input  logic [WORD_BYTES-1:0] wr_mask,
    input  logic [WORD_W-1:0]     wr_data,
    input  logic [IDX_W-1:0]      rd_idx_fwd,
    input  logic [IDX_W-1:0]      rd_idx_drain,
    output logic [WORD_W-1:0]     rd_data_fwd,
    output logic [WORD_BYTES-1:0] rd_mask_fwd,
    output logic [WORD_W-1:0]     rd_data_drain,
    output logic [WORD_BYTES-1:0] rd_mask_drain
);
    logic [WORD_W-1:0]     words  [ENTRIES];
    logic [WORD_BYTES-1:0] bvalid [ENTRIES];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int k = 0; k < WORD_BYTES; k++) begin
                if (wr_mask[k]) begin
                    words[wr_idx][k*8 +: 8] <= wr_data[k*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int e = 0; e < ENTRIES; e++) begin
                bvalid[e] <= '0;
            end
        end else if (wr_en) begin
            // a fresh line drops whatever the previous owner left.
            bvalid[wr_idx] <= wr_mask | (new_line ? '0 : bvalid[wr_idx]);
        end
    end

    assign rd_data_fwd   = words[rd_idx_fwd];
    assign rd_mask_fwd   = bvalid[rd_idx_fwd];
    assign rd_data_drain = words[rd_idx_drain];
    assign rd_mask_drain = bvalid[rd_idx_drain];

endmodule

// File: hdl/scb_evict_ctrl.sv
`timescale 1ns/10ps

module scb_evict_ctrl
    import scb_addr_pkg::*, scb_line_pkg::*;
#(
    parameter int  ENTRIES   = 8,
    parameter int  COUNTER_W = 3,
    parameter int  THRESH    = 6,
    localparam int IDX_W     = $clog2(ENTRIES)
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           flush,
    input  logic                           wr_en,
    input  logic [IDX_W-1:0]               wr_idx,
    input  logic [ENTRIES-1:0]             entry_valid,
    input  logic [ENTRIES-1:0][LINE_W-1:0] entry_lines,
    output logic                           write_start,
    output logic [IDX_W-1:0]               start_idx,
    output logic                           write_done,
    output logic [IDX_W-1:0]               done_idx,
    output logic                           drain_req,
    output logic [IDX_W-1:0]               drain_idx,
    input  logic [BANKS*WORD_W-1:0]        line_data,
    input  logic [LINE_BYTES-1:0]          line_mask,
    output logic                           cache_req,
    output logic [PADDR_W-1:0]             cache_addr,
    output logic [BANKS*WORD_W-1:0]        cache_data,
    output logic [LINE_BYTES-1:0]          cache_mask,
    input  logic                           cache_ack
);
    localparam int         OCC_W  = $clog2(ENTRIES + 1);
    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_READ = 2'd1;
    localparam logic [1:0] S_REQ  = 2'd2;

    logic [COUNTER_W-1:0] age [ENTRIES];
    logic [ENTRIES-1:0]   ready;
    logic [OCC_W-1:0]     occ;
    logic                 thresh_q;
    logic                 flush_q;
    logic [1:0]           state;
    logic [IDX_W-1:0]     pick_idx;
    logic [IDX_W-1:0]     victim_q;

    for (genvar i = 0; i < ENTRIES; i++) begin : g_ready
        assign ready[i] = entry_valid[i] &
                          ((age[i] == COUNTER_W'(1)) | thresh_q | flush | flush_q);
    end

    always_comb begin
        occ      = '0;
        pick_idx = '0;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            occ = occ + OCC_W'(entry_valid[i]);
            if (ready[i]) begin
                pick_idx = IDX_W'(i);
            end
        end
    end

    // one line in flight, so no ready entry is ever mid-write in idle.
    assign write_start = (state == S_IDLE) & (|ready) & ~cache_ack;
    assign start_idx   = pick_idx;
    assign drain_req   = (state == S_READ);
    assign drain_idx   = victim_q;
    assign cache_req   = (state == S_REQ);
    assign write_done  = cache_req & cache_ack;
    assign done_idx    = victim_q;
    assign cache_data  = line_data;
    assign cache_mask  = line_mask;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                age[i] <= COUNTER_W'(1);
            end
        end else if (wr_en) begin
            for (int i = 0; i < ENTRIES; i++) begin
                if (wr_idx == IDX_W'(i)) begin
                    age[i] <= '1;
                end else if (age[i] != COUNTER_W'(1)) begin
                    age[i] <= age[i] - 1'b1; // floor of one.
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            thresh_q <= 1'b0;
            flush_q  <= 1'b0;
            state    <= S_IDLE;
        end else begin
            thresh_q <= (occ > OCC_W'(THRESH));
            if (flush) begin
                flush_q <= 1'b1;
            end else if (!(|entry_valid)) begin
                flush_q <= 1'b0; // drained.
            end
            case (state)
                S_IDLE:  if (write_start) state <= S_READ;
                S_READ:  state <= S_REQ;
                default: if (cache_ack) state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (write_start) begin
            victim_q   <= pick_idx;
            cache_addr <= {entry_lines[pick_idx], {LINE_OFS_W{1'b0}}};
        end
    end

endmodule

// File: hdl/scb_forward.sv
`timescale 1ns/10ps

module scb_forward
    import scb_addr_pkg::*;
#(
    parameter int  ENTRIES = 8,
    localparam int IDX_W   = $clog2(ENTRIES)
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           load_en,
    input  logic [PAGE_W-1:0]              load_offset,
    input  logic [PTAG_W-1:0]              load_ptag,
    input  logic [ENTRIES-1:0]             entry_valid,
    input  logic [ENTRIES-1:0][LINE_W-1:0] entry_lines,
    output logic                           fwd_req,
    output logic [IDX_W-1:0]               fwd_idx,
    output logic [BANK_W-1:0]              fwd_bank
);
    scb_paddr_u         ld_addr;
    scb_paddr_u         ent_addr [ENTRIES];
    logic [ENTRIES-1:0] ofs_hit;
    logic [ENTRIES-1:0] ofs_hit_q;
    logic [ENTRIES-1:0] fwd_vec;
    logic [BANK_W-1:0]  bank_q;

    assign ld_addr = {{PTAG_W{1'b0}}, load_offset}; // tag not known yet.

    for (genvar j = 0; j < ENTRIES; j++) begin : g_cmp
        assign ent_addr[j] = {entry_lines[j], {LINE_OFS_W{1'b0}}};
        assign ofs_hit[j]  = load_en & entry_valid[j] &
                             (ent_addr[j].ld.page_ofs[PAGE_W-1:LINE_OFS_W] ==
                              ld_addr.ld.page_ofs[PAGE_W-1:LINE_OFS_W]);
        assign fwd_vec[j]  = ofs_hit_q[j] & (ent_addr[j].ld.ptag == load_ptag);
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ofs_hit_q <= '0;
        end else begin
            ofs_hit_q <= ofs_hit;
        end
    end

    always_ff @(posedge clk) begin
        bank_q <= ld_addr.st.bank;
    end

    always_comb begin
        fwd_idx = '0;
        for (int j = ENTRIES - 1; j >= 0; j--) begin
            if (fwd_vec[j]) begin
                fwd_idx = IDX_W'(j);
            end
        end
    end

    assign fwd_req  = |fwd_vec;
    assign fwd_bank = bank_q;

endmodule

// File: hdl/scb_line_pkg.sv
package scb_line_pkg;

    localparam int BANKS      = 4;                  // bank words per line.
    localparam int WORD_BYTES = 4;
    localparam int WORD_W     = WORD_BYTES * 8;
    localparam int LINE_BYTES = BANKS * WORD_BYTES; // cache write mask width.

endpackage

// File: hdl/scb_tag_array.sv
`timescale 1ns/10ps

module scb_tag_array
    import scb_addr_pkg::*;
#(
    parameter int  ENTRIES = 8,
    localparam int IDX_W   = $clog2(ENTRIES)
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           store_en,
    input  logic [PADDR_W-1:0]             store_addr,
    output logic                           store_conflict,
    output logic                           wr_en,
    output logic [IDX_W-1:0]               wr_idx,
    output logic [BANK_W-1:0]              wr_bank,
    output logic                           new_line,
    input  logic                           write_start,
    input  logic [IDX_W-1:0]               start_idx,
    input  logic                           write_done,
    input  logic [IDX_W-1:0]               done_idx,
    output logic [ENTRIES-1:0]             entry_valid,
    output logic [ENTRIES-1:0][LINE_W-1:0] entry_lines,
    output logic                           empty
);
    scb_paddr_u         addr;
    logic [ENTRIES-1:0] valid;
    logic [ENTRIES-1:0] writing;
    logic [ENTRIES-1:0] hit_vec;
    logic [ENTRIES-1:0] free_vec;
    logic [IDX_W-1:0]   hit_idx;
    logic [IDX_W-1:0]   free_idx;
    logic               hit;

    assign addr = store_addr;

    for (genvar i = 0; i < ENTRIES; i++) begin : g_match
        // an entry on its way to the cache takes no more merges.
        assign hit_vec[i] = valid[i] & ~writing[i] & (entry_lines[i] == addr.st.line);
    end

    assign free_vec = ~valid;

    always_comb begin
        hit_idx  = '0;
        free_idx = '0;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                hit_idx = IDX_W'(i);
            end
            if (free_vec[i]) begin
                free_idx = IDX_W'(i); // lowest free wins.
            end
        end
    end

    assign hit            = |hit_vec;
    assign store_conflict = store_en & ~hit & ~(|free_vec);
    assign wr_en          = store_en & ~store_conflict;
    assign new_line       = ~hit;
    assign wr_idx         = hit ? hit_idx : free_idx;
    assign wr_bank        = addr.st.bank;
    assign entry_valid    = valid;
    assign empty          = ~(|valid);

    always_ff @(posedge clk) begin
        if (wr_en && new_line) begin
            entry_lines[free_idx] <= addr.st.line;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid   <= '0;
            writing <= '0;
        end else begin
            if (wr_en && new_line) begin
                valid[free_idx] <= 1'b1;
            end
            if (write_start) begin
                writing[start_idx] <= 1'b1;
            end
            if (write_done) begin
                valid[done_idx]   <= 1'b0; // line now owned by the cache.
                writing[done_idx] <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/store_commit_buffer.sv
`timescale 1ns/10ps

module store_commit_buffer
    import scb_addr_pkg::*, scb_line_pkg::*;
#(
    parameter int ENTRIES   = 8,
    parameter int COUNTER_W = 3,
    parameter int THRESH    = 6
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    store_en,
    input  logic [PADDR_W-1:0]      store_addr,
    input  logic [WORD_W-1:0]       store_data,
    input  logic [WORD_BYTES-1:0]   store_mask,
    output logic                    store_conflict,
    input  logic                    load_en,
    input  logic [PAGE_W-1:0]       load_offset,
    input  logic [PTAG_W-1:0]       load_ptag,
    output logic [WORD_W-1:0]       fwd_data,
    output logic [WORD_BYTES-1:0]   fwd_mask,
    output logic                    cache_req,
    output logic [PADDR_W-1:0]      cache_addr,
    output logic [BANKS*WORD_W-1:0] cache_data,
    output logic [LINE_BYTES-1:0]   cache_mask,
    input  logic                    cache_ack,
    output logic                    empty
);
    localparam int IDX_W = $clog2(ENTRIES);

    logic                           wr_en;
    logic [IDX_W-1:0]               wr_idx;
    logic [BANK_W-1:0]              wr_bank;
    logic                           new_line;
    logic                           write_start;
    logic [IDX_W-1:0]               start_idx;
    logic                           write_done;
    logic [IDX_W-1:0]               done_idx;
    logic [ENTRIES-1:0]             entry_valid;
    logic [ENTRIES-1:0][LINE_W-1:0] entry_lines;
    logic                           drain_req;
    logic [IDX_W-1:0]               drain_idx;
    logic [BANKS*WORD_W-1:0]        line_data;
    logic [LINE_BYTES-1:0]          line_mask;
    logic                           fwd_req;
    logic [IDX_W-1:0]               fwd_idx;
    logic [BANK_W-1:0]              fwd_bank;

    scb_tag_array #(.ENTRIES(ENTRIES)) u_tag_array (.*);

    scb_data_array #(.ENTRIES(ENTRIES)) u_data_array (.*);

    scb_evict_ctrl #(
        .ENTRIES   (ENTRIES),
        .COUNTER_W (COUNTER_W),
        .THRESH    (THRESH)
    ) u_evict_ctrl (.*);

    scb_forward #(.ENTRIES(ENTRIES)) u_forward (.*);

endmodule

// File: store_commit_buffer.f
hdl/scb_addr_pkg.sv
hdl/scb_line_pkg.sv
hdl/scb_data_bank.sv
hdl/scb_data_array.sv
hdl/scb_tag_array.sv
hdl/scb_evict_ctrl.sv
hdl/scb_forward.sv
hdl/store_commit_buffer.sv
bench/scb_checker.sv
bench/tb_store_commit_buffer.sv
